/* resdmac.f */
source/resdmac_pkg.sv
source/addr_decoder.sv
source/ctrl_reg.sv
source/io_port.sv
source/bus_cycle.sv
source/resdmac.sv
verification/resdmac_chk.sv
verification/resdmac_monitor.sv
verification/resdmac_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module resdmac_tb \
    -f resdmac.f -o sim_resdmac
./obj_dir/sim_resdmac | tee sim.log

if grep -q "Done: errors found" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
echo "Simulation PASSED"

/* verification/resdmac_tb.sv */
// SCSI DMA controller testbench
`timescale 1ns/100ps

module resdmac_tb
    import resdmac_pkg::*;
();

    localparam int CLK_PERIOD = 40;
    localparam int RST_CYCLES = 8;
    localparam int ROW_CYCLES = 40;                // Budget per table row
    localparam logic       RD      = 1'b1;
    localparam logic       WR      = 1'b0;
    localparam logic [2:0] CS_NONE = 3'b111;       // {css_n, csx0_n, csx1_n}
    localparam logic [2:0] CS_S    = 3'b011;
    localparam logic [2:0] CS_X0   = 3'b101;
    localparam logic [2:0] CS_X1   = 3'b110;

    typedef struct packed {
        logic              rw;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [2:0]        dly;                    // iordy low cycles
        logic              ia;
        logic              ib;
        logic [DATA_W-1:0] exp_rdata;
        logic              exp_int_n;
        logic              exp_dma_n;
        logic [2:0]        exp_cs;
    } row_t;

    logic              sclk;
    logic              rst_n;
    bus_req_t          cpu_req;
    bus_rsp_t          cpu_rsp;
    logic              inta;
    logic              intb;
    logic              int_n;
    logic              dma_en_n;
    port_ctl_t         port_ctl;
    logic [PD_W-1:0]   pd_out;
    logic              pd_oe;
    logic [PD_W-1:0]   pd_in;
    logic              iordy;
    logic [DATA_W-1:0] exp_rdata;
    logic [2:0]        exp_cs;
    logic              exp_int_n;
    logic              exp_dma_en_n;
    logic              lvl_chk;                    // One cycle level compare
    int                cur_dly;
    int                low_cnt;
    int                mon_errs;
    int                asrt_errs;
    int                wd_cycles;
    integer            seed = 32'hd42631c9;
    row_t              rows[$];

    resdmac resdmac_i (.*);

    resdmac_monitor monitor_i (
        .sclk         (sclk),
        .rst_n        (rst_n),
        .cpu_rsp      (cpu_rsp),
        .port_ctl     (port_ctl),
        .pd_out       (pd_out),
        .pd_oe        (pd_oe),
        .int_n        (int_n),
        .dma_en_n     (dma_en_n),
        .iordy        (iordy),
        .exp_rdata    (exp_rdata),
        .exp_cs       (exp_cs),
        .exp_pd       (cpu_req.wdata[PD_W-1:0]),   // Low half goes to the device
        .exp_int_n    (exp_int_n),
        .exp_dma_en_n (exp_dma_en_n),
        .lvl_chk      (lvl_chk),
        .err_cnt      (mon_errs)
    );

    assign pd_in = 16'hA500 + 16'(cpu_req.addr);  // Device answers base plus word address

    initial begin
        sclk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) sclk = ~sclk;
        end
    end

    // Device model, iordy low for the row delay once a strobe falls
    initial begin
        iordy   = 1'b1;
        low_cnt = 0;
        forever begin
            @(posedge sclk);
            #2;
            if (port_ctl.ior_n && port_ctl.iow_n) begin
                low_cnt = 0;
                iordy   = 1'b1;                    // Idle ready
            end else begin
                low_cnt = low_cnt + 1;
                iordy   = (low_cnt > cur_dly);
            end
        end
    end

    task automatic add_row(input logic rw, input logic [ADDR_W-1:0] addr,
                           input logic [DATA_W-1:0] wdata, input logic [2:0] dly,
                           input logic ia, input logic ib, input logic [DATA_W-1:0] exp_rd,
                           input logic in_n, input logic dm_n, input logic [2:0] cs);
        rows.push_back('{rw, addr, wdata, dly, ia, ib, exp_rd, in_n, dm_n, cs});
    endtask

    task automatic build_table();
        logic [DATA_W-1:0] wtc_val;
        wtc_val = $random(seed);
        add_row(RD, REG_DAWR, 32'h0, 3'd0, 1'b0, 1'b0, 32'h0, 1'b1, 1'b1, CS_NONE); // Reset
        add_row(RD, REG_WTC, 32'h0, 3'd0, 1'b0, 1'b0, 32'h0, 1'b1, 1'b1, CS_NONE);
        add_row(RD, REG_CNTR, 32'h0, 3'd0, 1'b0, 1'b0, 32'h0, 1'b1, 1'b1, CS_NONE);
        add_row(RD, REG_ISTR, 32'h0, 3'd0, 1'b0, 1'b0, 32'h0, 1'b1, 1'b1, CS_NONE);
        add_row(WR, REG_DAWR, 32'hffff_ffff, 3'd0, 1'b0, 1'b0, 32'h0, 1'b1, 1'b1, CS_NONE);
        add_row(RD, REG_DAWR, 32'h0, 3'd0, 1'b0, 1'b0, 32'h3, 1'b1, 1'b1, CS_NONE); // 2 bits
        add_row(WR, REG_WTC, wtc_val, 3'd0, 1'b0, 1'b0, 32'h0, 1'b1, 1'b1, CS_NONE);
        add_row(RD, REG_WTC, 32'h0, 3'd0, 1'b0, 1'b0, wtc_val & 32'h00ff_ffff, 1'b1, 1'b1,
                CS_NONE);                          // 24 bits
        add_row(WR, REG_CNTR, 32'hffff_fffb, 3'd0, 1'b0, 1'b0, 32'h0, 1'b1, 1'b1, CS_NONE);
        add_row(RD, REG_CNTR, 32'h0, 3'd0, 1'b0, 1'b0, 32'h3b, 1'b1, 1'b1, CS_NONE); // INTEN off
        add_row(RD, REG_SP_DMA, 32'h0, 3'd0, 1'b0, 1'b0, 32'h0, 1'b1, 1'b1, CS_NONE);
        add_row(RD, REG_CLR_INT, 32'h0, 3'd0, 1'b0, 1'b0, 32'h0, 1'b1, 1'b1, CS_NONE);
        add_row(RD, 5'd3, 32'h0, 3'd0, 1'b0, 1'b0, 32'h0, 1'b1, 1'b1, CS_NONE);   // Holes
        add_row(RD, 5'd8, 32'h0, 3'd0, 1'b0, 1'b0, 32'h0, 1'b1, 1'b1, CS_NONE);
        add_row(WR, REG_ST_DMA, 32'h0, 3'd0, 1'b0, 1'b0, 32'h0, 1'b1, 1'b0, CS_NONE);
        add_row(RD, REG_ISTR, 32'h0, 3'd0, 1'b0, 1'b0, 32'h2, 1'b1, 1'b0, CS_NONE);
        add_row(WR, REG_FLUSH, 32'h0, 3'd0, 1'b0, 1'b0, 32'h0, 1'b1, 1'b0, CS_NONE);
        add_row(RD, REG_WTC, 32'h0, 3'd0, 1'b0, 1'b0, 32'h0, 1'b1, 1'b0, CS_NONE);
        add_row(WR, REG_SP_DMA, 32'h0, 3'd0, 1'b0, 1'b0, 32'h0, 1'b1, 1'b1, CS_NONE);
        add_row(RD, REG_ISTR, 32'h0, 3'd0, 1'b0, 1'b0, 32'h0, 1'b1, 1'b1, CS_NONE);
        add_row(RD, REG_ISTR, 32'h0, 3'd0, 1'b1, 1'b0, 32'h10, 1'b1, 1'b1, CS_NONE); // inta
        add_row(WR, REG_CNTR, 32'h4, 3'd0, 1'b0, 1'b0, 32'h0, 1'b0, 1'b1, CS_NONE);
        add_row(RD, REG_ISTR, 32'h0, 3'd0, 1'b0, 1'b0, 32'h11, 1'b0, 1'b1, CS_NONE);
        add_row(WR, REG_CLR_INT, 32'h0, 3'd0, 1'b0, 1'b0, 32'h0, 1'b1, 1'b1, CS_NONE);
        add_row(RD, REG_ISTR, 32'h0, 3'd0, 1'b0, 1'b0, 32'h0, 1'b1, 1'b1, CS_NONE);
        add_row(WR, REG_CNTR, 32'h0, 3'd0, 1'b0, 1'b0, 32'h0, 1'b1, 1'b1, CS_NONE);
        add_row(WR, REG_ST_DMA, 32'h0, 3'd0, 1'b0, 1'b0, 32'h0, 1'b1, 1'b0, CS_NONE);
        add_row(RD, REG_ISTR, 32'h0, 3'd0, 1'b0, 1'b1, 32'h0a, 1'b1, 1'b0, CS_NONE); // intb
        add_row(WR, REG_CNTR, 32'h4, 3'd0, 1'b0, 1'b0, 32'h0, 1'b0, 1'b0, CS_NONE);
        add_row(RD, REG_ISTR, 32'h0, 3'd0, 1'b0, 1'b0, 32'h0b, 1'b0, 1'b0, CS_NONE);
        add_row(WR, REG_CLR_INT, 32'h0, 3'd0, 1'b0, 1'b0, 32'h0, 1'b1, 1'b0, CS_NONE);
        add_row(RD, REG_ISTR, 32'h0, 3'd0, 1'b0, 1'b0, 32'h02, 1'b1, 1'b0, CS_NONE);
        add_row(WR, REG_SP_DMA, 32'h0, 3'd0, 1'b0, 1'b0, 32'h0, 1'b1, 1'b1, CS_NONE);
        add_row(WR, 5'd16, 32'h1234_5678, 3'd0, 1'b0, 1'b0, 32'h0, 1'b1, 1'b1, CS_S); // Port
        add_row(WR, 5'd25, 32'hdead_beef, 3'd1, 1'b0, 1'b0, 32'h0, 1'b1, 1'b1, CS_X0);
        add_row(WR, 5'd30, 32'h0000_c3c3, 3'd0, 1'b0, 1'b0, 32'h0, 1'b1, 1'b1, CS_X1);
        add_row(RD, 5'd16, 32'h0, 3'd0, 1'b0, 1'b0, 32'h0000_a510, 1'b1, 1'b1, CS_S);
        add_row(RD, 5'd27, 32'h0, 3'd3, 1'b0, 1'b0, 32'h0000_a51b, 1'b1, 1'b1, CS_X0);
        add_row(RD, 5'd31, 32'h0, 3'd2, 1'b0, 1'b0, 32'h0000_a51f, 1'b1, 1'b1, CS_X1);
    endtask

    task automatic wait_ack(input logic level);
        do begin
            @(posedge sclk);
            #2;                                    // Look after the edge settles
        end while (cpu_rsp.ack != level);
    endtask

    // One four phase CPU cycle, then a level compare
    task automatic run_row(input row_t r);
        @(posedge sclk);
        #2;
        inta         = r.ia;
        intb         = r.ib;
        cur_dly      = int'(r.dly);
        exp_rdata    = r.exp_rdata;
        exp_cs       = r.exp_cs;
        exp_int_n    = r.exp_int_n;
        exp_dma_en_n = r.exp_dma_n;
        cpu_req      = '{req: 1'b1, rw: r.rw, addr: r.addr, wdata: r.wdata};
        wait_ack(1'b1);
        cpu_req.req = 1'b0;                        // Phase 3
        wait_ack(1'b0);
        @(posedge sclk);
        #2;
        lvl_chk = 1'b1;
        @(posedge sclk);
        #2;
        lvl_chk = 1'b0;
    endtask

    initial begin
        rst_n        = 1'b0;
        cpu_req      = '0;
        inta         = 1'b0;
        intb         = 1'b0;
        exp_rdata    = '0;
        exp_cs       = CS_NONE;
        exp_int_n    = 1'b1;
        exp_dma_en_n = 1'b1;
        lvl_chk      = 1'b0;
        cur_dly      = 0;
        build_table();
        wd_cycles = rows.size() * ROW_CYCLES + RST_CYCLES;
        repeat (RST_CYCLES) @(posedge sclk);
        #2 rst_n = 1'b1;
        foreach (rows[i]) begin
            run_row(rows[i]);
        end
        repeat (2) @(posedge sclk);
        asrt_errs = resdmac_i.bus_cycle_i.cpu_chk_i.fails + resdmac_i.io_port_i.port_chk_i.fails;
        $display("Rows %0d, monitor errors %0d, assertion failures %0d",
                 rows.size(), mon_errs, asrt_errs);
        if (mon_errs == 0 && asrt_errs == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge sclk);
        $display("Timeout, the table did not finish within %0d clock cycles", wd_cycles);
        $display("Done: errors found");
        $finish;
    end

endmodule

/* verification/resdmac_monitor.sv */
// DUT port checker
`timescale 1ns/100ps

module resdmac_monitor
    import resdmac_pkg::*;
(
    input  logic              sclk,
    input  logic              rst_n,
    input  bus_rsp_t          cpu_rsp,
    input  port_ctl_t         port_ctl,
    input  logic [PD_W-1:0]   pd_out,
    input  logic              pd_oe,
    input  logic              int_n,
    input  logic              dma_en_n,
    input  logic              iordy,
    input  logic [DATA_W-1:0] exp_rdata,
    input  logic [2:0]        exp_cs,             // {css_n, csx0_n, csx1_n}
    input  logic [PD_W-1:0]   exp_pd,
    input  logic              exp_int_n,
    input  logic              exp_dma_en_n,
    input  logic              lvl_chk,
    output int                err_cnt
);

    logic       ack_q;
    logic       rdy_seen;                         // iordy high during a strobe
    logic       cs_seen;
    logic [2:0] cs_now;

    assign cs_now = {port_ctl.css_n, port_ctl.csx0_n, port_ctl.csx1_n};

    always @(posedge sclk) begin
        if (!rst_n) begin
            err_cnt  = 0;
            ack_q    <= 1'b0;
            rdy_seen <= 1'b0;
            cs_seen  <= 1'b0;
        end else begin
            ack_q <= cpu_rsp.ack;
            if (cpu_rsp.ack && !ack_q) begin      // Rising ack
                if (cpu_rsp.rdata != exp_rdata) begin
                    $display("** Error: cpu_rsp.rdata = 0x%h, expected 0x%h",
                             cpu_rsp.rdata, exp_rdata);
                    err_cnt = err_cnt + 1;
                end
                if (cs_now != 3'b111 && !rdy_seen) begin
                    $display("Port cycle acknowledged before iordy was seen high");
                    err_cnt = err_cnt + 1;
                end
            end
            if ((!port_ctl.ior_n || !port_ctl.iow_n) && iordy) begin
                rdy_seen <= 1'b1;
            end
            if (cs_now != 3'b111) begin
                cs_seen <= 1'b1;
                if (cs_now != exp_cs) begin       // Only the addressed window
                    $display("** Error: {css_n,csx0_n,csx1_n} = 0x%h, expected 0x%h",
                             cs_now, exp_cs);
                    err_cnt = err_cnt + 1;
                end
            end
            if (!port_ctl.iow_n && (!pd_oe || pd_out != exp_pd)) begin
                $display("** Error: pd_oe = 0x%h pd_out = 0x%h, expected 0x1 and 0x%h",
                         pd_oe, pd_out, exp_pd);
                err_cnt = err_cnt + 1;
            end
            if (!port_ctl.ior_n && pd_oe) begin   // Read strobe into a driven bus
                $display("Read strobe low while the port drives pd_out");
                err_cnt = err_cnt + 1;
            end
            if (lvl_chk) begin
                rdy_seen <= 1'b0;
                cs_seen  <= 1'b0;
                if (int_n != exp_int_n) begin
                    $display("** Error: int_n = 0x%h, expected 0x%h", int_n, exp_int_n);
                    err_cnt = err_cnt + 1;
                end
                if (dma_en_n != exp_dma_en_n) begin
                    $display("** Error: dma_en_n = 0x%h, expected 0x%h", dma_en_n, exp_dma_en_n);
                    err_cnt = err_cnt + 1;
                end
                if (port_ctl != 5'h1f || pd_oe) begin  // Port idle between rows
                    $display("** Error: port_ctl = 0x%h pd_oe = 0x%h, expected 0x1f and 0x0",
                             port_ctl, pd_oe);
                    err_cnt = err_cnt + 1;
                end
                if (exp_cs != 3'b111 && !cs_seen) begin
                    $display("Port cycle finished without any chip select going low");
                    err_cnt = err_cnt + 1;
                end
            end
        end
    end

endmodule

/* verification/resdmac_chk.sv */
// Handshake and strobe assertions
`timescale 1ns/100ps

module resdmac_chk
    import resdmac_pkg::*;
(
    input logic      sclk,
    input logic      rst_n,
    input logic      req,
    input logic      ack,
    input port_ctl_t ctl                          // Tied high where no pins exist
);

    int fails = 0;

    a_ack_fall: assert property (@(posedge sclk) disable iff (!rst_n)
        $fell(ack) |-> !$past(req))
        else begin
            fails = fails + 1;
            $error("ack dropped while req was still high");
        end

    a_ack_rise: assert property (@(posedge sclk) disable iff (!rst_n)
        $rose(ack) |-> $past(req))
        else begin
            fails = fails + 1;
            $error("ack raised without a request");
        end

    a_strobe_excl: assert property (@(posedge sclk) disable iff (!rst_n)
        ctl.ior_n || ctl.iow_n)
        else begin
            fails = fails + 1;
            $error("ior_n and iow_n low together");
        end

    a_strobe_cs: assert property (@(posedge sclk) disable iff (!rst_n)
        !(ctl.ior_n && ctl.iow_n) |-> !(ctl.css_n && ctl.csx0_n && ctl.csx1_n))
        else begin
            fails = fails + 1;
            $error("strobe low with no chip select");
        end

endmodule

bind bus_cycle resdmac_chk cpu_chk_i (
    .sclk  (sclk),
    .rst_n (rst_n),
    .req   (cpu_req.req),
    .ack   (cpu_rsp.ack),
    .ctl   ('1)
);

bind io_port resdmac_chk port_chk_i (
    .sclk  (sclk),
    .rst_n (rst_n),
    .req   (port_req.req),
    .ack   (port_rsp.ack),
    .ctl   (port_ctl)
);

/* source/resdmac.sv */
// SCSI DMA controller top level
`timescale 1ns/100ps

module resdmac
    import resdmac_pkg::*;
(
    input  logic            sclk,                 // CPU clock
    input  logic            rst_n,
    input  bus_req_t        cpu_req,
    output bus_rsp_t        cpu_rsp,
    input  logic            inta,
    input  logic            intb,
    output logic            int_n,                // To INT2
    output logic            dma_en_n,             // Address generator enable
    output port_ctl_t       port_ctl,
    output logic [PD_W-1:0] pd_out,
    output logic            pd_oe,
    input  logic [PD_W-1:0] pd_in,
    input  logic            iordy
);

    logic [ADDR_W-1:0] dec_addr;
    reg_sel_t          reg_sel;
    port_sel_t         port_sel;
    reg_acc_t          reg_acc;
    logic [DATA_W-1:0] reg_rdata;
    port_req_t         port_req;
    port_rsp_t         port_rsp;

    bus_cycle bus_cycle_i (
        .sclk      (sclk),
        .rst_n     (rst_n),
        .cpu_req   (cpu_req),
        .cpu_rsp   (cpu_rsp),
        .dec_addr  (dec_addr),
        .reg_sel   (reg_sel),
        .port_sel  (port_sel),
        .reg_acc   (reg_acc),
        .reg_rdata (reg_rdata),
        .port_req  (port_req),
        .port_rsp  (port_rsp)
    );

    addr_decoder addr_decoder_i (
        .addr     (dec_addr),
        .reg_sel  (reg_sel),
        .port_sel (port_sel)
    );

    ctrl_reg ctrl_reg_i (
        .sclk      (sclk),
        .rst_n     (rst_n),
        .reg_acc   (reg_acc),
        .inta      (inta),
        .intb      (intb),
        .reg_rdata (reg_rdata),
        .int_n     (int_n),
        .dma_en_n  (dma_en_n)
    );

    io_port io_port_i (
        .sclk     (sclk),
        .rst_n    (rst_n),
        .port_req (port_req),
        .port_rsp (port_rsp),
        .port_ctl (port_ctl),
        .pd_out   (pd_out),
        .pd_oe    (pd_oe),
        .pd_in    (pd_in),
        .iordy    (iordy)
    );

endmodule

/* source/bus_cycle.sv */
// CPU bus cycle sequencer
`timescale 1ns/100ps

module bus_cycle
    import resdmac_pkg::*;
(
    input  logic              sclk,
    input  logic              rst_n,
    input  bus_req_t          cpu_req,
    output bus_rsp_t          cpu_rsp,
    output logic [ADDR_W-1:0] dec_addr,           // To decoder
    input  reg_sel_t          reg_sel,
    input  port_sel_t         port_sel,
    output reg_acc_t          reg_acc,
    input  logic [DATA_W-1:0] reg_rdata,
    output port_req_t         port_req,
    input  port_rsp_t         port_rsp
);

    typedef enum logic [2:0] {
        B_IDLE, B_DECODE, B_REG, B_PORT, B_DONE
    } bus_state_t;

    bus_state_t        state;
    logic              rw_q;
    logic [DATA_W-1:0] wdata_q;
    logic              is_strobe;

    assign is_strobe = (reg_sel == SEL_ST_DMA) || (reg_sel == SEL_FLUSH) ||
                       (reg_sel == SEL_CLR_INT) || (reg_sel == SEL_SP_DMA);

    // Request capture
    always_ff @(posedge sclk) begin
        if (state == B_IDLE && cpu_req.req) begin
            rw_q     <= cpu_req.rw;
            dec_addr <= cpu_req.addr;
            wdata_q  <= cpu_req.wdata;
        end
    end

    always_ff @(posedge sclk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= B_IDLE;
            cpu_rsp  <= '0;
            reg_acc  <= '0;
            port_req <= '0;
        end else begin
            case (state)
                B_IDLE: begin
                    if (cpu_req.req) begin
                        state <= B_DECODE;
                    end
                end
                B_DECODE: begin
                    if (port_sel != PSEL_NONE) begin
                        state    <= B_PORT;
                        port_req <= '{req: 1'b1, rw: rw_q, sel: port_sel,
                                      wdata: wdata_q[PD_W-1:0]};
                    end else begin
                        state   <= B_REG;
                        reg_acc <= '{wr: ~rw_q | is_strobe, sel: reg_sel, wdata: wdata_q};
                    end
                end
                B_REG: begin
                    state         <= B_DONE;
                    reg_acc.wr    <= 1'b0;        // Single cycle write
                    reg_acc.sel   <= SEL_NONE;
                    cpu_rsp.ack   <= 1'b1;
                    cpu_rsp.rdata <= rw_q ? reg_rdata : '0;
                end
                B_PORT: begin
                    if (port_rsp.ack) begin
                        state         <= B_DONE;
                        port_req.req  <= 1'b0;
                        cpu_rsp.ack   <= 1'b1;
                        cpu_rsp.rdata <= rw_q ? DATA_W'(port_rsp.rdata) : '0; // Zero extend
                    end
                end
                default: begin
                    if (!cpu_req.req) begin       // Master ended the cycle
                        state       <= B_IDLE;
                        cpu_rsp.ack <= 1'b0;
                    end
                end
            endcase
        end
    end

endmodule

/* source/io_port.sv */
// Peripheral port cycle engine
`timescale 1ns/100ps

module io_port
    import resdmac_pkg::*;
(
    input  logic            sclk,
    input  logic            rst_n,
    input  port_req_t       port_req,
    output port_rsp_t       port_rsp,
    output port_ctl_t       port_ctl,             // Active low pins
    output logic [PD_W-1:0] pd_out,
    output logic            pd_oe,
    input  logic [PD_W-1:0] pd_in,
    input  logic            iordy                 // High when device ready
);

    typedef enum logic [2:0] {
        P_IDLE, P_SETUP, P_STROBE, P_DONE, P_HOLD
    } port_state_t;

    port_state_t           state;
    logic [PORT_CNT_W-1:0] cnt;                   // Strobe low cycles
    logic                  strobe_end;

    assign strobe_end = (state == P_STROBE) && (cnt == STROBE_LAST) && iordy;

    always_ff @(posedge sclk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= P_IDLE;
            cnt          <= '0;
            port_ctl     <= '1;                   // All deasserted
            pd_oe        <= 1'b0;
            port_rsp.ack <= 1'b0;
        end else begin
            case (state)
                P_IDLE: begin
                    if (port_req.req && (port_req.sel != PSEL_NONE)) begin
                        state           <= P_SETUP;
                        pd_oe           <= ~port_req.rw; // Drive bus on writes
                        port_ctl.css_n  <= (port_req.sel != PSEL_CSS);
                        port_ctl.csx0_n <= (port_req.sel != PSEL_CSX0);
                        port_ctl.csx1_n <= (port_req.sel != PSEL_CSX1);
                    end
                end
                P_SETUP: begin
                    state          <= P_STROBE;
                    cnt            <= '0;
                    port_ctl.ior_n <= ~port_req.rw;
                    port_ctl.iow_n <= port_req.rw;
                end
                P_STROBE: begin
                    if (strobe_end) begin
                        state          <= P_DONE;
                        port_ctl.ior_n <= 1'b1;
                        port_ctl.iow_n <= 1'b1;
                        pd_oe          <= 1'b0;
                        port_rsp.ack   <= 1'b1;
                        port_rsp.rdata <= pd_in;  // Latched as strobe rises
                    end else if (cnt != STROBE_LAST) begin
                        cnt <= cnt + 1'b1;        // Min width before iordy
                    end
                end
                P_DONE: begin
                    if (!port_req.req) begin      // Release on req low
                        state        <= P_HOLD;
                        port_ctl     <= '1;
                        port_rsp.ack <= 1'b0;
                    end
                end
                default: begin
                    state <= P_IDLE;              // Hold gap before next cycle
                end
            endcase
        end
    end

    // Write data register
    always_ff @(posedge sclk) begin
        if (state == P_IDLE && port_req.req) begin
            pd_out <= port_req.wdata;
        end
    end

endmodule

/* source/ctrl_reg.sv */
// DMA control and status registers
`timescale 1ns/100ps

module ctrl_reg
    import resdmac_pkg::*;
(
    input  logic              sclk,
    input  logic              rst_n,
    input  reg_acc_t          reg_acc,            // From bus sequencer
    input  logic              inta,               // SCSI chip interrupt
    input  logic              intb,               // Spare interrupt
    output logic [DATA_W-1:0] reg_rdata,
    output logic              int_n,
    output logic              dma_en_n
);

    logic [DAWR_W-1:0] dawr;
    logic [WTC_W-1:0]  wtc;
    logic [CNTR_W-1:0] cntr;
    logic              inta_lat;
    logic              intb_lat;
    logic              dma_act;
    logic              int_f;
    logic              clr_int;
    logic [DATA_W-1:0] istr;

    assign clr_int  = reg_acc.wr && (reg_acc.sel == SEL_CLR_INT);
    assign int_f    = (inta_lat || intb_lat) && cntr[CNTR_INTEN_BIT]; // Gated by INTEN
    assign dma_en_n = ~dma_act;                   // Address generator enable

    always_comb begin
        istr                 = '0;
        istr[ISTR_INT_F_BIT] = int_f;
        istr[ISTR_DMA_BIT]   = dma_act;
        istr[ISTR_INTB_BIT]  = intb_lat;
        istr[ISTR_INTA_BIT]  = inta_lat;
    end

    always_ff @(posedge sclk or negedge rst_n) begin
        if (!rst_n) begin
            dawr     <= '0;
            wtc      <= '0;
            cntr     <= '0;
            inta_lat <= 1'b0;
            intb_lat <= 1'b0;
            dma_act  <= 1'b0;
            int_n    <= 1'b1;
        end else begin
            inta_lat <= inta || (inta_lat && !clr_int); // Live source wins over clear
            intb_lat <= intb || (intb_lat && !clr_int);
            int_n    <= ~int_f;                   // One register delay
            if (reg_acc.wr) begin
                case (reg_acc.sel)
                    SEL_DAWR:   dawr    <= reg_acc.wdata[DAWR_W-1:0];
                    SEL_WTC:    wtc     <= reg_acc.wdata[WTC_W-1:0];
                    SEL_CNTR:   cntr    <= reg_acc.wdata[CNTR_W-1:0];
                    SEL_ST_DMA: dma_act <= 1'b1;
                    SEL_SP_DMA: dma_act <= 1'b0;
                    SEL_FLUSH:  wtc     <= '0;    // FIFO flush resets count
                    default:    ;                 // ISTR read only, CLR_INT above
                endcase
            end
        end
    end

    // Read mux, strobes and holes return zero
    always_comb begin
        case (reg_acc.sel)
            SEL_DAWR: reg_rdata = DATA_W'(dawr);
            SEL_WTC:  reg_rdata = DATA_W'(wtc);
            SEL_CNTR: reg_rdata = DATA_W'(cntr);
            SEL_ISTR: reg_rdata = istr;
            default:  reg_rdata = '0;
        endcase
    end

endmodule

/* source/addr_decoder.sv */
// Register and chip select decoder
`timescale 1ns/100ps

module addr_decoder
    import resdmac_pkg::*;
(
    input  logic [ADDR_W-1:0] addr,               // Latched word address
    output reg_sel_t          reg_sel,
    output port_sel_t         port_sel
);

    always_comb begin
        reg_sel  = SEL_NONE;                      // Default miss
        port_sel = PSEL_NONE;
        if (addr >= PORT_CSX1_BASE) begin         // Top window first
            port_sel = PSEL_CSX1;
        end else if (addr >= PORT_CSX0_BASE) begin
            port_sel = PSEL_CSX0;
        end else if (addr >= PORT_CSS_BASE) begin // SCSI chip window
            port_sel = PSEL_CSS;
        end else begin
            // Internal register space
            case (addr)
                REG_DAWR: begin
                    reg_sel = SEL_DAWR;
                end
                REG_WTC: begin
                    reg_sel = SEL_WTC;
                end
                REG_CNTR: begin
                    reg_sel = SEL_CNTR;
                end
                REG_ST_DMA: begin
                    reg_sel = SEL_ST_DMA;
                end
                REG_FLUSH: begin
                    reg_sel = SEL_FLUSH;
                end
                REG_CLR_INT: begin
                    reg_sel = SEL_CLR_INT;
                end
                REG_ISTR: begin
                    reg_sel = SEL_ISTR;
                end
                REG_SP_DMA: begin
                    reg_sel = SEL_SP_DMA;
                end
                default: begin
                    reg_sel = SEL_NONE;           // Unmapped hole
                end
            endcase
        end
    end

endmodule

/* source/resdmac_pkg.sv */
// SCSI DMA controller definitions
package resdmac_pkg;

    localparam int ADDR_W = 5;                    // CPU word address, lines 6 to 2
    localparam int DATA_W = 32;                   // CPU data bus
    localparam int PD_W   = 16;                   // Peripheral data bus

    localparam int DAWR_W = 2;                    // Data acknowledge width
    localparam int WTC_W  = 24;                   // Word transfer count
    localparam int CNTR_W = 6;                    // Control register

    // Register map, word index
    localparam logic [ADDR_W-1:0] REG_DAWR    = 5'd0;
    localparam logic [ADDR_W-1:0] REG_WTC     = 5'd1;
    localparam logic [ADDR_W-1:0] REG_CNTR    = 5'd2;
    localparam logic [ADDR_W-1:0] REG_ST_DMA  = 5'd4;  // Strobe
    localparam logic [ADDR_W-1:0] REG_FLUSH   = 5'd5;  // Strobe
    localparam logic [ADDR_W-1:0] REG_CLR_INT = 5'd6;  // Strobe
    localparam logic [ADDR_W-1:0] REG_ISTR    = 5'd7;  // Read only
    localparam logic [ADDR_W-1:0] REG_SP_DMA  = 5'd15; // Strobe

    localparam logic [ADDR_W-1:0] PORT_CSS_BASE  = 5'd16; // 16..23
    localparam logic [ADDR_W-1:0] PORT_CSX0_BASE = 5'd24; // 24..27
    localparam logic [ADDR_W-1:0] PORT_CSX1_BASE = 5'd28; // 28..31

    localparam int CNTR_INTEN_BIT = 2;            // Interrupt enable
    localparam int ISTR_INT_F_BIT = 0;            // Latched interrupt while enabled
    localparam int ISTR_DMA_BIT   = 1;            // DMA active
    localparam int ISTR_INTB_BIT  = 3;
    localparam int ISTR_INTA_BIT  = 4;

    localparam int PORT_STROBE_MIN = 2;           // Min strobe low cycles
    localparam int PORT_CNT_W      = 2;
    localparam logic [PORT_CNT_W-1:0] STROBE_LAST = PORT_CNT_W'(PORT_STROBE_MIN - 1);

    typedef enum logic [3:0] {
        SEL_NONE, SEL_DAWR, SEL_WTC, SEL_CNTR, SEL_ST_DMA,
        SEL_FLUSH, SEL_CLR_INT, SEL_ISTR, SEL_SP_DMA
    } reg_sel_t;

    typedef enum logic [1:0] {
        PSEL_NONE, PSEL_CSS, PSEL_CSX0, PSEL_CSX1
    } port_sel_t;

    typedef struct packed {
        logic              req;
        logic              rw;                    // 1 = read
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic              ack;
        logic [DATA_W-1:0] rdata;
    } bus_rsp_t;

    typedef struct packed {
        logic              wr;                    // Single cycle write or strobe
        reg_sel_t          sel;
        logic [DATA_W-1:0] wdata;
    } reg_acc_t;

    typedef struct packed {
        logic            req;
        logic            rw;
        port_sel_t       sel;
        logic [PD_W-1:0] wdata;
    } port_req_t;

    typedef struct packed {
        logic            ack;
        logic [PD_W-1:0] rdata;
    } port_rsp_t;

    typedef struct packed {
        logic css_n;
        logic csx0_n;
        logic csx1_n;
        logic ior_n;
        logic iow_n;
    } port_ctl_t;

endpackage
